// File: Makefile
# Verilator build for the memory stage testbench

VERILATOR  ?= verilator
TOP        := memSubsystemTb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_TEXT  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status follows the pass line in the simulator output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/memSubsystemTb.sv
// Self-checking testbench for the memory stage with a word model and concurrent checks

`timescale 1ns/1ps

module memSubsystemTb
    import memOpPkg::*, memMapPkg::*;
();

    // ----------------------------------------------------------------------
    // Run length
    // ----------------------------------------------------------------------
    localparam int     CLK_PERIOD   = 20;
    localparam int     RESET_CYCLES = 16;
    localparam int     RANDOM_SEED  = 24421;
    localparam int     NUM_WORDS    = 1 << WORD_ADDR_WIDTH;
    localparam int     WORD_PAIRS   = 64;     // Store then load
    localparam int     LANE_ROUNDS  = 16;     // 16 ops each
    localparam int     EXT_ROUNDS   = 16;     // 21 ops each
    localparam int     FETCH_OPS    = 96;
    localparam int     BAD_ROUNDS   = 8;      // 5 ops each
    localparam int     IDLE_OPS     = 8;      // Before first load and at the end
    localparam int     NUM_OPS      = NUM_WORDS + 2 * WORD_PAIRS + 16 * LANE_ROUNDS
                                    + 21 * EXT_ROUNDS + FETCH_OPS + 5 * BAD_ROUNDS + IDLE_OPS;
    localparam int     WATCHDOG_NS  = (RESET_CYCLES + 4 * NUM_OPS) * CLK_PERIOD;
    localparam memOp_e IDLE_OP      = memOp_e'(3'b111);   // Unlisted code that reads as zero

    // DUT inputs
    logic                  clkA = 1'b0;
    logic                  RST;
    logic                  memWrEn;
    memOp_e                memOp;
    logic [DATA_WIDTH-1:0] rwAddr;
    logic [DATA_WIDTH-1:0] wrData;
    logic [DATA_WIDTH-1:0] pcAddr;
    logic                  flushD;
    logic                  stallEn;

    // DUT outputs
    logic [DATA_WIDTH-1:0] loadData;
    logic [DATA_WIDTH-1:0] instr;

    // Expected results
    // Stage D is set with the stimulus and stage Q lines up with the output
    logic                  loadChkD   = 1'b0;
    logic                  loadChkQ   = 1'b0;
    logic [DATA_WIDTH-1:0] loadExpD   = '0;
    logic [DATA_WIDTH-1:0] loadExpQ   = '0;
    logic                  fetchChkD  = 1'b0;
    logic                  fetchChkQ  = 1'b0;
    logic [DATA_WIDTH-1:0] fetchExpD  = '0;
    logic [DATA_WIDTH-1:0] fetchExpQ  = '0;
    logic                  loadIssued = 1'b0;   // Any real load driven yet

    logic [DATA_WIDTH-1:0] model [NUM_WORDS];   // Reference memory

    int resetErrors  = 0;
    int idleErrors   = 0;
    int loadErrors   = 0;
    int fetchErrors  = 0;
    int bubbleErrors = 0;

    always #(CLK_PERIOD / 2) clkA = ~clkA;

    memSubsystem uut (
        .clkA     (clkA),
        .RST      (RST),
        .memWrEn  (memWrEn),
        .memOp    (memOp),
        .rwAddr   (rwAddr),
        .wrData   (wrData),
        .pcAddr   (pcAddr),
        .flushD   (flushD),
        .stallEn  (stallEn),
        .loadData (loadData),
        .instr    (instr)
    );

    // One-cycle read latency on both paths
    always @(posedge clkA) begin
        loadChkQ  <= loadChkD;
        loadExpQ  <= loadExpD;
        fetchChkQ <= fetchChkD;
        fetchExpQ <= fetchExpD;
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    resetInstrCheck: assert property (@(posedge clkA) RST |-> instr == RESET_INSTR)
        else begin
            resetErrors = resetErrors + 1;
            $display("FAIL instr expected 0x%08h got 0x%08h", RESET_INSTR, $sampled(instr));
        end

    idleLoadCheck: assert property (@(posedge clkA) disable iff (RST)
        !loadIssued |-> loadData == '0)
        else begin
            idleErrors = idleErrors + 1;
            $display("FAIL loadData expected 0x%08h got 0x%08h", 32'h0, $sampled(loadData));
        end

    loadValueCheck: assert property (@(posedge clkA) disable iff (RST)
        loadChkQ |-> loadData == loadExpQ)
        else begin
            loadErrors = loadErrors + 1;
            $display("FAIL loadData expected 0x%08h got 0x%08h",
                     $sampled(loadExpQ), $sampled(loadData));
        end

    fetchValueCheck: assert property (@(posedge clkA) disable iff (RST)
        (fetchChkQ && !flushD && !stallEn) |-> instr == fetchExpQ)
        else begin
            fetchErrors = fetchErrors + 1;
            $display("FAIL instr expected 0x%08h got 0x%08h",
                     $sampled(fetchExpQ), $sampled(instr));
        end

    bubbleCheck: assert property (@(posedge clkA) disable iff (RST)
        (flushD || stallEn) |-> instr == NOP_INSTR)
        else begin
            bubbleErrors = bubbleErrors + 1;
            $display("FAIL instr expected 0x%08h got 0x%08h", NOP_INSTR, $sampled(instr));
        end

    // ----------------------------------------------------------------------
    // Reference model helpers
    // ----------------------------------------------------------------------
    function automatic logic [DATA_WIDTH-1:0] byteAddr(input logic [WORD_ADDR_WIDTH-1:0] idx,
                                                       input logic [1:0] off);
        return {{(DATA_WIDTH - WORD_ADDR_WIDTH - 2){1'b0}}, idx, off};
    endfunction

    function automatic logic [WORD_ADDR_WIDTH-1:0] randIdx();
        logic [31:0] r;
        r = $urandom;
        return r[WORD_ADDR_WIDTH-1:0];
    endfunction

    function automatic logic [1:0] randOff();
        logic [31:0] r;
        r = $urandom;
        return r[1:0];
    endfunction

    // Little endian lanes
    // A halfword picks its pair from bit 1
    function automatic logic [31:0] mergeStore(input logic [31:0] old, input memOp_e op,
                                               input logic [1:0] off, input logic [31:0] data);
        logic [31:0] res;
        res = old;
        case (op)
            MEM_BYTE:     res[8*off +: 8] = data[7:0];
            MEM_HALFWORD: begin
                if (off[1]) res[31:16] = data[15:0];
                else        res[15:0]  = data[15:0];
            end
            MEM_WORD:     res = data;
            default:      res = old;
        endcase
        return res;
    endfunction

    function automatic logic [31:0] expectLoad(input logic [31:0] word, input memOp_e op,
                                               input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            MEM_BYTE:              return {{24{b[7]}}, b};
            MEM_BYTE_UNSIGNED:     return {24'h0, b};
            MEM_HALFWORD:          return {{16{h[15]}}, h};
            MEM_HALFWORD_UNSIGNED: return {16'h0, h};
            MEM_WORD:              return word;
            default:               return 32'h0;   // Unlisted codes
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    // Idle defaults for one cycle that callers override after it
    task automatic nextEdge();
        @(posedge clkA);
        memWrEn   <= 1'b0;
        memOp     <= IDLE_OP;
        flushD    <= 1'b0;
        stallEn   <= 1'b0;
        loadChkD  <= 1'b1;
        loadExpD  <= '0;      // Idle and store cycles read back zero
        fetchChkD <= 1'b0;
    endtask

    task automatic storeOp(input logic [WORD_ADDR_WIDTH-1:0] idx, input memOp_e op,
                           input logic [1:0] off, input logic [31:0] data);
        nextEdge();
        memWrEn    <= 1'b1;
        memOp      <= op;
        rwAddr     <= byteAddr(idx, off);
        wrData     <= data;                     // Upper bits left as noise
        model[idx]  = mergeStore(model[idx], op, off, data);
    endtask

    // Noise on wrData makes each load a store attempt with memWrEn low
    task automatic loadOp(input logic [WORD_ADDR_WIDTH-1:0] idx, input memOp_e op,
                          input logic [1:0] off);
        nextEdge();
        memOp      <= op;
        rwAddr     <= byteAddr(idx, off);
        wrData     <= $urandom;
        loadExpD   <= expectLoad(model[idx], op, off);
        loadIssued <= 1'b1;
    endtask

    task automatic fetchOp(input logic [WORD_ADDR_WIDTH-1:0] idx);
        logic [31:0] r;
        r = $urandom;
        nextEdge();
        pcAddr    <= byteAddr(idx, r[5:4]);      // Low bits ignored by fetch
        flushD    <= (r[1:0] == 2'b00);          // Masks the previous fetch
        stallEn   <= (r[3:2] == 2'b00);
        fetchChkD <= 1'b1;
        fetchExpD <= model[idx];
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [WORD_ADDR_WIDTH-1:0] idx;
        logic [31:0]                r;
        int                         total;
        void'($urandom(RANDOM_SEED));
        RST     <= 1'b1;
        memWrEn <= 1'b0;
        memOp   <= IDLE_OP;
        rwAddr  <= '0;
        wrData  <= '0;
        pcAddr  <= '0;
        flushD  <= 1'b1;   // Reset must win over a bubble
        stallEn <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clkA);
        RST     <= 1'b0;
        flushD  <= 1'b0;
        stallEn <= 1'b0;
        repeat (IDLE_OPS / 2) nextEdge();   // loadData must stay zero

        // Whole memory gets random words first
        for (int i = 0; i < NUM_WORDS; i++) begin
            storeOp(WORD_ADDR_WIDTH'(i), MEM_WORD, randOff(), $urandom);
        end

        for (int i = 0; i < WORD_PAIRS; i++) begin
            idx = randIdx();
            storeOp(idx, MEM_WORD, randOff(), $urandom);
            loadOp(idx, MEM_WORD, randOff());
        end

        // Byte and halfword lanes including odd halfword offsets
        for (int i = 0; i < LANE_ROUNDS; i++) begin
            idx = randIdx();
            for (int o = 0; o < 4; o++) begin
                storeOp(idx, MEM_BYTE, 2'(o), $urandom);
                loadOp(idx, MEM_WORD, 2'b00);
            end
            for (int o = 0; o < 4; o++) begin
                storeOp(idx, MEM_HALFWORD, 2'(o), $urandom);
                loadOp(idx, MEM_WORD, 2'b00);
            end
        end

        // Sign and zero extension at each offset
        for (int i = 0; i < EXT_ROUNDS; i++) begin
            idx = randIdx();
            storeOp(idx, MEM_WORD, 2'b00, $urandom);
            for (int o = 0; o < 4; o++) begin
                loadOp(idx, MEM_BYTE, 2'(o));
                loadOp(idx, MEM_BYTE_UNSIGNED, 2'(o));
                loadOp(idx, MEM_HALFWORD, 2'(o));
                loadOp(idx, MEM_HALFWORD_UNSIGNED, 2'(o));
                loadOp(idx, MEM_WORD, 2'(o));
            end
        end

        for (int i = 0; i < FETCH_OPS; i++) begin
            fetchOp(randIdx());
        end

        // Unlisted op codes followed by a write attempt with memWrEn low and a reload
        for (int i = 0; i < BAD_ROUNDS; i++) begin
            idx = randIdx();
            loadOp(idx, memOp_e'(3'b011), randOff());
            loadOp(idx, memOp_e'(3'b110), randOff());
            loadOp(idx, memOp_e'(3'b111), randOff());
            r = $urandom;
            loadOp(idx, (r[0] ? MEM_BYTE : (r[1] ? MEM_HALFWORD : MEM_WORD)), randOff());
            loadOp(idx, MEM_WORD, 2'b00);
        end

        repeat (IDLE_OPS / 2) nextEdge();   // Let the last checks fire

        total = resetErrors + idleErrors + loadErrors + fetchErrors + bubbleErrors;
        $display("Errors: reset=%0d idle=%0d load=%0d fetch=%0d bubble=%0d total=%0d",
                 resetErrors, idleErrors, loadErrors, fetchErrors, bubbleErrors, total);
        if (total == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the test sequence did not complete within %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: files.f
source/memOpPkg.sv
source/memMapPkg.sv
source/dataPortIf.sv
source/dataPort.sv
source/fetchPort.sv
source/byteWriteRam.sv
source/memSubsystem.sv
dv/memSubsystemTb.sv

// File: source/byteWriteRam.sv
// Shared true dual-port RAM with byte write enables on port A and read-only fetch on port B

`timescale 1ns/1ps

module byteWriteRam
    import memMapPkg::*;
#(
    parameter int addrWidth = WORD_ADDR_WIDTH   // Depth is 2**addrWidth words
) (
    input  logic                  clkA,
    dataPortIf.mem                bus,            // Port A, loads and stores
    input  logic [addrWidth-1:0]  fetchWordAddr,  // Port B index
    output logic [DATA_WIDTH-1:0] fetchWord       // Port B data
);

    // Word storage, byte columns addressable on their own
    logic [NUM_LANES-1:0][LANE_WIDTH-1:0] memArray [2**addrWidth];

    // Port A index, low bits of the bus index
    // Depths up to WORD_ADDR_WIDTH are supported this way
    logic [addrWidth-1:0] portAIdx;

    assign portAIdx = bus.wordAddr[addrWidth-1:0];

    // ----------------------------------------------------------------------
    // Port A
    // ----------------------------------------------------------------------
    always_ff @(posedge clkA) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (bus.byteEn[i]) begin
                memArray[portAIdx][i] <= bus.wrData[i*LANE_WIDTH +: LANE_WIDTH];
            end
        end
        bus.rdData <= memArray[portAIdx];   // Read first, old contents
    end

    // ----------------------------------------------------------------------
    // Port B
    // ----------------------------------------------------------------------
    // Fetch never writes
    // Same clock as port A
    always_ff @(posedge clkA) begin
        fetchWord <= memArray[fetchWordAddr];
    end

endmodule

// File: source/dataPort.sv
// Data port that steers store bytes onto RAM lanes and extracts and extends load fields

`timescale 1ns/1ps

module dataPort
    import memOpPkg::*, memMapPkg::*;
(
    input  logic                  clkA,
    input  logic                  RST,
    input  logic                  memWrEn,    // Store strobe from the M stage
    input  memOp_e                memOp,      // funct3 of the load or store
    input  logic [DATA_WIDTH-1:0] rwAddr,     // Byte address from the ALU
    input  logic [DATA_WIDTH-1:0] wrData,     // rs2 value, right aligned
    output logic [DATA_WIDTH-1:0] loadData,   // Extended load result
    dataPortIf.ctrl               bus
);

    logic [NUM_LANES-1:0] laneSel;     // Lanes touched by the op, before the strobe
    memWord_u             storeWord;   // Store data replicated across lanes

    memOp_e               opQ;         // Op of the access now returning from RAM
    logic [1:0]           offsetQ;     // Its byte offset
    memWord_u             loadWord;    // RAM read word
    logic [LANE_WIDTH-1:0] pickedByte;
    logic [HALF_WIDTH-1:0] pickedHalf;

    // ----------------------------------------------------------------------
    // Request side
    // ----------------------------------------------------------------------

    assign bus.wordAddr = rwAddr[WORD_ADDR_WIDTH+1:2];   // Drop byte offset

    // Lane decode from size and the low address bits
    always_comb begin
        laneSel = '0;
        case (memOp)
            MEM_BYTE: begin
                laneSel[rwAddr[1:0]] = 1'b1;                // Single lane
            end
            MEM_HALFWORD: begin
                laneSel[{rwAddr[1], 1'b0}] = 1'b1;          // Bit 0 ignored
                laneSel[{rwAddr[1], 1'b1}] = 1'b1;
            end
            MEM_WORD: begin
                laneSel = '1;                               // Low two bits ignored
            end
            default: begin
                laneSel = '0;                               // LBU and LHU codes never store
            end
        endcase
    end

    assign bus.byteEn = memWrEn ? laneSel : '0;   // Reads still happen with no lanes set

    // Copy the low byte or halfword into every slot
    // Whichever lanes are enabled then pick up the right data
    always_comb begin
        storeWord = wrData;
        case (memOp)
            MEM_BYTE: begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    storeWord.lanes[i] = wrData[LANE_WIDTH-1:0];
                end
            end
            MEM_HALFWORD: begin
                for (int i = 0; i < NUM_LANES / 2; i++) begin
                    storeWord.halves[i] = wrData[HALF_WIDTH-1:0];
                end
            end
            default: begin
                storeWord = wrData;                         // Word goes out as is
            end
        endcase
    end

    assign bus.wrData = storeWord;

    // ----------------------------------------------------------------------
    // Return side
    // ----------------------------------------------------------------------

    // RAM read takes one edge, so the op and offset are kept alongside it
    always_ff @(posedge clkA) begin
        offsetQ <= rwAddr[1:0];
        if (RST || memWrEn) begin
            opQ <= memOp_e'(3'b111);   // Unused code so loadData reads zero
        end else begin
            opQ <= memOp;
        end
    end

    assign loadWord   = bus.rdData;
    assign pickedByte = loadWord.lanes[offsetQ];
    assign pickedHalf = loadWord.halves[offsetQ[1]];   // Halfword uses bit 1 only

    // Width casts extend, signed source gives sign extension
    always_comb begin
        case (opQ)
            MEM_BYTE:              loadData = DATA_WIDTH'($signed(pickedByte));
            MEM_BYTE_UNSIGNED:     loadData = DATA_WIDTH'(pickedByte);
            MEM_HALFWORD:          loadData = DATA_WIDTH'($signed(pickedHalf));
            MEM_HALFWORD_UNSIGNED: loadData = DATA_WIDTH'(pickedHalf);
            MEM_WORD:              loadData = loadWord;
            default:               loadData = '0;   // Store cycle, reset or bad code
        endcase
    end

endmodule

// File: source/dataPortIf.sv
// Data port bus between the load/store logic and port A of the shared RAM

`timescale 1ns/1ps

interface dataPortIf
    import memMapPkg::*;
();

    logic [WORD_ADDR_WIDTH-1:0] wordAddr;   // Word index, byte offset stripped
    logic [NUM_LANES-1:0]       byteEn;     // One bit per byte lane, zero means read only
    logic [DATA_WIDTH-1:0]      wrData;     // Already steered onto the lanes
    logic [DATA_WIDTH-1:0]      rdData;     // Old word, one cycle after wordAddr

    // Load/store side
    modport ctrl (
        output wordAddr, byteEn, wrData,
        input  rdData
    );

    // RAM side
    modport mem (
        input  wordAddr, byteEn, wrData,
        output rdData
    );

endinterface

// File: source/fetchPort.sv
// Fetch port that word-aligns the PC and substitutes NOP or zero for the fetched word

`timescale 1ns/1ps

module fetchPort
    import memOpPkg::*, memMapPkg::*;
(
    input  logic                       RST,
    input  logic [DATA_WIDTH-1:0]      pcAddr,          // PC from the F stage
    input  logic                       flushD,          // Kill the instruction entering D
    input  logic                       stallEn,         // Hold D with a bubble
    input  logic [DATA_WIDTH-1:0]      fetchWord,       // RAM port B data
    output logic [WORD_ADDR_WIDTH-1:0] fetchWordAddr,   // RAM port B index
    output logic [DATA_WIDTH-1:0]      instr            // Instruction into decode
);

    // Instructions are always word aligned
    // pcAddr[1:0] is never looked at
    assign fetchWordAddr = pcAddr[WORD_ADDR_WIDTH+1:2];

    // ----------------------------------------------------------------------
    // Instruction select
    // ----------------------------------------------------------------------
    // Acts on the word already out of the RAM
    // Flush and stall take effect in the same cycle they are raised
    always_comb begin
        if (RST) begin
            instr = RESET_INSTR;        // Zero so reset bubbles look unlike flushes
        end else if (flushD || stallEn) begin
            instr = NOP_INSTR;          // Bubble
        end else begin
            instr = fetchWord;
        end
    end

endmodule

// File: source/memMapPkg.sv
// Memory map package with word geometry and the byte and halfword views of a data word
package memMapPkg;

    // ----------------------------------------------------------------------
    // Geometry
    // ----------------------------------------------------------------------

    localparam int DATA_WIDTH      = 32;               // Bits per memory word
    localparam int NUM_LANES       = 4;                // Byte columns per word
    localparam int LANE_WIDTH      = 8;                // Bits per byte column
    localparam int HALF_WIDTH      = 2 * LANE_WIDTH;   // Bits per halfword
    localparam int WORD_ADDR_WIDTH = 10;               // 1024 words of 4 bytes

    // Byte address bits 1 and 0 select the lane
    // Everything from bit 2 up to bit WORD_ADDR_WIDTH+1 is the word index

    // ----------------------------------------------------------------------
    // Lane views of one word
    // ----------------------------------------------------------------------
    // Little endian throughout
    // lanes[0] holds the byte at offset 0
    // halves[0] holds offsets 0 and 1, halves[1] holds offsets 2 and 3

    typedef union packed {
        logic [NUM_LANES-1:0][LANE_WIDTH-1:0]   lanes;    // Byte view
        logic [NUM_LANES/2-1:0][HALF_WIDTH-1:0] halves;   // Halfword view
    } memWord_u;

endpackage

// File: source/memOpPkg.sv
// Memory operation package with RV32I load/store size codes and fixed instruction words
package memOpPkg;

    // ----------------------------------------------------------------------
    // Load and store operations
    // ----------------------------------------------------------------------
    // Values match funct3 of the LOAD and STORE opcodes, so the decode
    // stage can pass the field through untouched

    typedef enum logic [2:0] {
        MEM_BYTE              = 3'b000,  // LB and SB
        MEM_HALFWORD          = 3'b001,  // LH and SH
        MEM_WORD              = 3'b010,  // LW and SW
        MEM_BYTE_UNSIGNED     = 3'b100,  // LBU (no store form)
        MEM_HALFWORD_UNSIGNED = 3'b101   // LHU (no store form)
    } memOp_e;

    // Codes 3'b011, 3'b110 and 3'b111 are not listed above
    // Loads with them return zero and stores with them write nothing

    // ----------------------------------------------------------------------
    // Instruction words handed to decode
    // ----------------------------------------------------------------------

    // Canonical NOP is addi x0 x0 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    // All zeros is an illegal encoding in RV32I
    // Used while in reset so it differs from a flush bubble
    localparam logic [31:0] RESET_INSTR = 32'h0000_0000;

endpackage

// File: source/memSubsystem.sv
// Memory stage top joining the load/store path and the fetch path on one shared RAM

`timescale 1ns/1ps

module memSubsystem
    import memOpPkg::*, memMapPkg::*;
(
    input  logic                  clkA,
    input  logic                  RST,

    // Load/store from the M stage
    input  logic                  memWrEn,    // Store when high
    input  memOp_e                memOp,      // Size and sign
    input  logic [DATA_WIDTH-1:0] rwAddr,     // ALU result as byte address
    input  logic [DATA_WIDTH-1:0] wrData,     // rs2 value

    // Fetch from the F stage
    input  logic [DATA_WIDTH-1:0] pcAddr,
    input  logic                  flushD,     // From hazard unit
    input  logic                  stallEn,    // From hazard unit

    output logic [DATA_WIDTH-1:0] loadData,   // One cycle after the load address
    output logic [DATA_WIDTH-1:0] instr       // One cycle after pcAddr
);

    // ----------------------------------------------------------------------
    // Internal links
    // ----------------------------------------------------------------------

    dataPortIf ramBus ();                            // Port A

    logic [WORD_ADDR_WIDTH-1:0] fetchWordAddr;       // Port B index
    logic [DATA_WIDTH-1:0]      fetchWord;           // Port B data

    // ----------------------------------------------------------------------
    // Access paths and the RAM they share
    // ----------------------------------------------------------------------

    dataPort dataSide (
        .clkA     (clkA),
        .RST      (RST),
        .memWrEn  (memWrEn),
        .memOp    (memOp),
        .rwAddr   (rwAddr),
        .wrData   (wrData),
        .loadData (loadData),
        .bus      (ramBus.ctrl)
    );

    fetchPort fetchSide (
        .RST           (RST),
        .pcAddr        (pcAddr),
        .flushD        (flushD),
        .stallEn       (stallEn),
        .fetchWord     (fetchWord),
        .fetchWordAddr (fetchWordAddr),
        .instr         (instr)
    );

    byteWriteRam #(
        .addrWidth (WORD_ADDR_WIDTH)
    ) sharedRam (
        .clkA          (clkA),
        .bus           (ramBus.mem),
        .fetchWordAddr (fetchWordAddr),
        .fetchWord     (fetchWord)
    );

endmodule
